// File: axil_pkg.sv
// shared widths, AXI-lite channel payloads and FSM encodings used by RTL and testbench
package axil_pkg;

  // --------------------------------------------------
  // bus geometry
  // --------------------------------------------------
  localparam int DATA_WIDTH = 64;
  localparam int ADDR_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;  // one strobe bit per byte

  // fixed attribute values driven by the master
  localparam logic [7:0] AXI_LEN_SINGLE   = 8'd0;     // single beat, no bursts
  localparam logic [1:0] AXI_SIZE_8B      = 2'd3;     // 2**3 bytes per beat
  localparam logic [1:0] AXI_LOCK_NORMAL  = 2'b00;
  localparam logic [3:0] AXI_CACHE_DEV_NB = 4'b0000;  // device, non-bufferable
  localparam logic [2:0] AXI_PROT_UNPRIV  = 3'b000;
  localparam logic [2:0] AXI_PROT_SECURE  = 3'b000;
  localparam logic [2:0] AXI_PROT_DATA    = 3'b000;

  typedef logic [DATA_WIDTH-1:0] axil_data_t;
  typedef logic [ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [STRB_WIDTH-1:0] axil_strb_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,  // the only type driven
    BURST_WRAP  = 2'b10
  } axil_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_e;

  // --------------------------------------------------
  // payloads
  // --------------------------------------------------
  typedef struct packed {
    logic       wr;     // 1 = store
    logic [1:0] size;
    axil_addr_t addr;
    axil_strb_t strb;
    axil_data_t wdata;
  } rw_req_t;

  typedef struct packed {
    axil_addr_t  addr;
    logic [7:0]  len;
    logic [1:0]  size;
    axil_burst_e burst;
    logic [1:0]  lock;
    logic [3:0]  cache;
    logic [2:0]  prot;
  } axil_aw_t;  // shared by aw and ar

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
    logic       last;
  } axil_w_t;

  typedef struct packed {
    axil_data_t data;
    axil_resp_e resp;
    logic       last;
  } axil_r_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_READ} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_WRITE, WR_RESP} wr_state_e;
  typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_e;

endpackage

// File: mem_port_arbiter.sv
// fixed-priority arbiter that grants load/store over fetch and holds one request for the master
`timescale 1ns/100ps

module mem_port_arbiter (
  input  logic                   i_aclk,
  input  logic                   i_rst_n,

  // fetch port, read only
  input  logic                   i_if_req,
  input  axil_pkg::axil_addr_t   i_if_addr,
  output logic                   o_if_data_ok,
  output axil_pkg::axil_data_t   o_if_rdata,

  // load/store port
  input  logic                   i_ls_req,
  input  axil_pkg::rw_req_t      i_ls_req_data,
  output logic                   o_ls_addr_ok,
  output logic                   o_ls_data_ok,
  output axil_pkg::axil_data_t   o_ls_rdata,

  // held request towards the AXI-lite master
  output logic                   o_rw_req,
  output axil_pkg::rw_req_t      o_rw_req_data,
  input  logic                   i_rw_addr_ok,
  input  logic                   i_rw_data_ok,
  input  axil_pkg::axil_data_t   i_rw_rdata
);

  axil_pkg::arb_state_e state_q;
  logic                 owner_ls_q;   // 1 = load/store holds the grant
  logic                 busy;
  axil_pkg::rw_req_t    if_as_req;    // fetch shaped as a full-word read
  axil_pkg::rw_req_t    req_q;

  assign busy = (state_q == axil_pkg::ARB_BUSY);

  assign if_as_req = '{
    wr:    1'b0,
    size:  axil_pkg::AXI_SIZE_8B,
    addr:  i_if_addr,
    strb:  '0,
    wdata: '0
  };

  // --------------------------------------------------
  // grant FSM
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state_q    <= axil_pkg::ARB_IDLE;
      owner_ls_q <= 1'b0;
    end else begin
      case (state_q)
        axil_pkg::ARB_IDLE: begin
          if (i_ls_req || i_if_req) begin
            state_q    <= axil_pkg::ARB_BUSY;
            owner_ls_q <= i_ls_req;              // load/store wins a tie
          end
        end
        axil_pkg::ARB_BUSY: begin
          if (i_rw_data_ok) begin
            state_q <= axil_pkg::ARB_IDLE;
          end
        end
        default: state_q <= axil_pkg::ARB_IDLE;
      endcase
    end
  end

  // winner's payload, frozen while busy
  always_ff @(posedge i_aclk) begin
    if (!busy) begin
      req_q <= i_ls_req ? i_ls_req_data : if_as_req;
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------
  assign o_rw_req      = busy & ~i_rw_data_ok;    // released in the completion cycle
  assign o_rw_req_data = req_q;

  // completions go back to the owner only
  assign o_ls_addr_ok  = busy & owner_ls_q & i_rw_addr_ok;
  assign o_ls_data_ok  = busy & owner_ls_q & i_rw_data_ok;
  assign o_if_data_ok  = busy & ~owner_ls_q & i_rw_data_ok;

  assign o_ls_rdata    = owner_ls_q ? i_rw_rdata : '0;
  assign o_if_rdata    = owner_ls_q ? '0 : i_rw_rdata;

endmodule

// File: axil_master_wrap.sv
// AXI-lite master that turns the held single-beat request into address, data and response beats
`timescale 1ns/100ps

module axil_master_wrap (
  input  logic                   i_aclk,
  input  logic                   i_rst_n,

  // held request side
  input  logic                   i_rw_req,
  input  axil_pkg::rw_req_t      i_rw_req_data,
  output logic                   o_rw_addr_ok,
  output logic                   o_rw_data_ok,
  output axil_pkg::axil_data_t   o_rw_rdata,

  // write address channel
  output axil_pkg::axil_aw_t     o_aw,
  output logic                   o_awvalid,
  input  logic                   i_awready,

  // write data channel
  output axil_pkg::axil_w_t      o_w,
  output logic                   o_wvalid,
  input  logic                   i_wready,

  // write response channel
  input  axil_pkg::axil_b_t      i_b,
  input  logic                   i_bvalid,
  output logic                   o_bready,

  // read address channel
  output axil_pkg::axil_aw_t     o_ar,
  output logic                   o_arvalid,
  input  logic                   i_arready,

  // read data channel
  input  axil_pkg::axil_r_t      i_r,
  input  logic                   i_rvalid,
  output logic                   o_rready
);

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  axil_pkg::rd_state_e rd_state_q;
  axil_pkg::wr_state_e wr_state_q;
  axil_pkg::axil_aw_t  addr_beat;     // common aw/ar payload

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------
  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid  & i_wready;
  assign b_fire  = o_bready  & i_bvalid;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = o_rready  & i_rvalid;

  // --------------------------------------------------
  // read FSM
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rd_state_q <= axil_pkg::RD_IDLE;
    end else begin
      case (rd_state_q)
        axil_pkg::RD_IDLE: if (i_rw_req && !i_rw_req_data.wr) rd_state_q <= axil_pkg::RD_ADDR;
        axil_pkg::RD_ADDR: if (ar_fire) rd_state_q <= axil_pkg::RD_READ;
        axil_pkg::RD_READ: if (r_fire)  rd_state_q <= axil_pkg::RD_IDLE;
        default:           rd_state_q <= axil_pkg::RD_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // write FSM
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wr_state_q <= axil_pkg::WR_IDLE;
    end else begin
      case (wr_state_q)
        axil_pkg::WR_IDLE:  if (i_rw_req && i_rw_req_data.wr) wr_state_q <= axil_pkg::WR_ADDR;
        axil_pkg::WR_ADDR:  if (aw_fire) wr_state_q <= axil_pkg::WR_WRITE;
        axil_pkg::WR_WRITE: if (w_fire)  wr_state_q <= axil_pkg::WR_RESP;
        axil_pkg::WR_RESP:  if (b_fire)  wr_state_q <= axil_pkg::WR_IDLE;
        default:            wr_state_q <= axil_pkg::WR_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // channel payloads
  // --------------------------------------------------
  assign addr_beat = '{
    addr:  i_rw_req_data.addr,
    len:   axil_pkg::AXI_LEN_SINGLE,
    size:  i_rw_req_data.size,
    burst: axil_pkg::BURST_INCR,
    lock:  axil_pkg::AXI_LOCK_NORMAL,
    cache: axil_pkg::AXI_CACHE_DEV_NB,
    prot:  axil_pkg::AXI_PROT_UNPRIV | axil_pkg::AXI_PROT_SECURE | axil_pkg::AXI_PROT_DATA
  };

  assign o_aw      = addr_beat;
  assign o_awvalid = (wr_state_q == axil_pkg::WR_ADDR);

  assign o_w       = '{data: i_rw_req_data.wdata, strb: i_rw_req_data.strb, last: 1'b1};
  assign o_wvalid  = (wr_state_q == axil_pkg::WR_WRITE);

  assign o_bready  = (wr_state_q == axil_pkg::WR_RESP);   // bresp not inspected

  assign o_ar      = addr_beat;
  assign o_arvalid = (rd_state_q == axil_pkg::RD_ADDR);
  assign o_rready  = (rd_state_q == axil_pkg::RD_READ);

  // request side handshake
  assign o_rw_addr_ok = ar_fire | w_fire;
  assign o_rw_data_ok = r_fire  | b_fire;
  assign o_rw_rdata   = i_r.data;            // valid only with data_ok on a read

endmodule

// File: axil_sram_slave.sv
// AXI-lite SRAM slave with byte strobes, aliased word index and programmable wait states
`timescale 1ns/100ps

module axil_sram_slave #(
  parameter int MEM_AWORDS  = 6,   // log2 of depth in words
  parameter int WAIT_CYCLES = 2
) (
  input  logic                 i_aclk,
  input  logic                 i_rst_n,

  input  axil_pkg::axil_aw_t   i_aw,
  input  logic                 i_awvalid,
  output logic                 o_awready,

  input  axil_pkg::axil_w_t    i_w,
  input  logic                 i_wvalid,
  output logic                 o_wready,

  output axil_pkg::axil_b_t    o_b,
  output logic                 o_bvalid,
  input  logic                 i_bready,

  input  axil_pkg::axil_aw_t   i_ar,
  input  logic                 i_arvalid,
  output logic                 o_arready,

  output axil_pkg::axil_r_t    o_r,
  output logic                 o_rvalid,
  input  logic                 i_rready
);

  localparam int OFFS_BITS = $clog2(axil_pkg::STRB_WIDTH);
  localparam int DEPTH     = 1 << MEM_AWORDS;
  localparam int CNT_W     = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
  localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(WAIT_CYCLES);

  // channel slots in the wait-state arrays
  localparam int CH_AW  = 0;
  localparam int CH_W   = 1;
  localparam int CH_B   = 2;
  localparam int CH_AR  = 3;
  localparam int CH_R   = 4;
  localparam int NUM_CH = 5;

  axil_pkg::axil_data_t  mem [DEPTH];
  axil_pkg::axil_data_t  rdata_q;
  logic [MEM_AWORDS-1:0] aw_idx_q;

  logic aw_held_q;                   // address taken, data not yet
  logic b_pend_q;
  logic r_pend_q;

  logic [NUM_CH-1:0] ch_req;         // channel wants to handshake
  logic [NUM_CH-1:0] ch_go;          // wait satisfied
  logic [NUM_CH-1:0] ch_fire;
  logic [CNT_W-1:0]  wait_cnt [NUM_CH];

  // --------------------------------------------------
  // wait-state insertion
  // --------------------------------------------------
  assign ch_req[CH_AW] = i_awvalid & ~aw_held_q & ~b_pend_q;
  assign ch_req[CH_W]  = i_wvalid & aw_held_q;
  assign ch_req[CH_B]  = b_pend_q;
  assign ch_req[CH_AR] = i_arvalid & ~r_pend_q;
  assign ch_req[CH_R]  = r_pend_q;

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      ch_go[i] = ch_req[i] && (wait_cnt[i] == CNT_DONE);
    end
  end

  assign ch_fire[CH_AW] = ch_go[CH_AW];
  assign ch_fire[CH_W]  = ch_go[CH_W];
  assign ch_fire[CH_B]  = ch_go[CH_B] & i_bready;
  assign ch_fire[CH_AR] = ch_go[CH_AR];
  assign ch_fire[CH_R]  = ch_go[CH_R] & i_rready;

  always_ff @(posedge i_aclk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (!i_rst_n || ch_fire[i]) begin
        wait_cnt[i] <= '0;
      end else if (ch_req[i] && wait_cnt[i] != CNT_DONE) begin
        wait_cnt[i] <= wait_cnt[i] + 1'b1;    // saturates at CNT_DONE
      end
    end
  end

  // --------------------------------------------------
  // transaction tracking
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      aw_held_q <= 1'b0;
      b_pend_q  <= 1'b0;
      r_pend_q  <= 1'b0;
    end else begin
      if (ch_fire[CH_AW])     aw_held_q <= 1'b1;
      else if (ch_fire[CH_W]) aw_held_q <= 1'b0;
      if (ch_fire[CH_W])      b_pend_q  <= 1'b1;
      else if (ch_fire[CH_B]) b_pend_q  <= 1'b0;
      if (ch_fire[CH_AR])     r_pend_q  <= 1'b1;
      else if (ch_fire[CH_R]) r_pend_q  <= 1'b0;
    end
  end

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (ch_fire[CH_AW]) begin
      aw_idx_q <= i_aw.addr[OFFS_BITS +: MEM_AWORDS];   // upper bits alias
    end
    if (ch_fire[CH_W]) begin
      for (int b = 0; b < axil_pkg::STRB_WIDTH; b++) begin
        if (i_w.strb[b]) mem[aw_idx_q][8*b +: 8] <= i_w.data[8*b +: 8];
      end
    end
    if (ch_fire[CH_AR]) begin
      rdata_q <= mem[i_ar.addr[OFFS_BITS +: MEM_AWORDS]];
    end
  end

  assign o_awready = ch_go[CH_AW];
  assign o_wready  = ch_go[CH_W];
  assign o_bvalid  = ch_go[CH_B];
  assign o_arready = ch_go[CH_AR];
  assign o_rvalid  = ch_go[CH_R];

  assign o_b = '{resp: axil_pkg::RESP_OKAY};
  assign o_r = '{data: rdata_q, resp: axil_pkg::RESP_OKAY, last: 1'b1};

endmodule

// File: mem_subsys_top.sv
// memory subsystem top that wires the port arbiter, AXI-lite master and SRAM slave together
`timescale 1ns/100ps

module mem_subsys_top #(
  parameter int MEM_AWORDS  = 6,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                   i_aclk,
  input  logic                   i_rst_n,

  input  logic                   i_if_req,
  input  axil_pkg::axil_addr_t   i_if_addr,
  output logic                   o_if_data_ok,
  output axil_pkg::axil_data_t   o_if_rdata,

  input  logic                   i_ls_req,
  input  axil_pkg::rw_req_t      i_ls_req_data,
  output logic                   o_ls_addr_ok,
  output logic                   o_ls_data_ok,
  output axil_pkg::axil_data_t   o_ls_rdata
);

  // --------------------------------------------------
  // arbiter to master
  logic                 rw_req;
  axil_pkg::rw_req_t    rw_req_data;
  logic                 rw_addr_ok;
  logic                 rw_data_ok;
  axil_pkg::axil_data_t rw_rdata;

  // --------------------------------------------------
  // AXI-lite between master and slave
  axil_pkg::axil_aw_t   aw;
  logic                 awvalid;
  logic                 awready;
  axil_pkg::axil_w_t    w;
  logic                 wvalid;
  logic                 wready;
  axil_pkg::axil_b_t    b;
  logic                 bvalid;
  logic                 bready;
  axil_pkg::axil_aw_t   ar;
  logic                 arvalid;
  logic                 arready;
  axil_pkg::axil_r_t    r;
  logic                 rvalid;
  logic                 rready;

  mem_port_arbiter u_arbiter (
    .i_aclk        (i_aclk),
    .i_rst_n       (i_rst_n),
    .i_if_req      (i_if_req),
    .i_if_addr     (i_if_addr),
    .o_if_data_ok  (o_if_data_ok),
    .o_if_rdata    (o_if_rdata),
    .i_ls_req      (i_ls_req),
    .i_ls_req_data (i_ls_req_data),
    .o_ls_addr_ok  (o_ls_addr_ok),
    .o_ls_data_ok  (o_ls_data_ok),
    .o_ls_rdata    (o_ls_rdata),
    .o_rw_req      (rw_req),
    .o_rw_req_data (rw_req_data),
    .i_rw_addr_ok  (rw_addr_ok),
    .i_rw_data_ok  (rw_data_ok),
    .i_rw_rdata    (rw_rdata)
  );

  axil_master_wrap u_master (
    .i_aclk        (i_aclk),
    .i_rst_n       (i_rst_n),
    .i_rw_req      (rw_req),
    .i_rw_req_data (rw_req_data),
    .o_rw_addr_ok  (rw_addr_ok),
    .o_rw_data_ok  (rw_data_ok),
    .o_rw_rdata    (rw_rdata),
    .o_aw          (aw),
    .o_awvalid     (awvalid),
    .i_awready     (awready),
    .o_w           (w),
    .o_wvalid      (wvalid),
    .i_wready      (wready),
    .i_b           (b),
    .i_bvalid      (bvalid),
    .o_bready      (bready),
    .o_ar          (ar),
    .o_arvalid     (arvalid),
    .i_arready     (arready),
    .i_r           (r),
    .i_rvalid      (rvalid),
    .o_rready      (rready)
  );

  axil_sram_slave #(
    .MEM_AWORDS  (MEM_AWORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_sram (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_aw      (aw),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_w       (w),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_b       (b),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_ar      (ar),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_r       (r),
    .o_rvalid  (rvalid),
    .i_rready  (rready)
  );

endmodule

// File: tb_mem_subsys_sva.sv
// AXI-lite handshake assertions, bound into every axil_master_wrap instance
`timescale 1ns/100ps

module tb_mem_subsys_sva (
  input logic i_aclk,
  input logic i_rst_n,
  input logic i_awvalid,
  input logic i_awready,
  input logic i_wvalid,
  input logic i_wready,
  input logic i_arvalid,
  input logic i_arready,
  input logic i_addr_ok
);

  // --------------------------------------------------
  // valid stays up until accepted
  // --------------------------------------------------
  aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_awvalid && !i_awready |=> i_awvalid)
    else $error("awvalid dropped before awready");

  ar_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_arvalid && !i_arready |=> i_arvalid)
    else $error("arvalid dropped before arready");

  w_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_wvalid && !i_wready |=> i_wvalid)
    else $error("wvalid dropped before wready");

  // address and data phases are sequential in the write FSM
  aw_w_excl: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    !(i_awvalid && i_wvalid))
    else $error("awvalid and wvalid high together");

  addr_ok_fire: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_addr_ok |-> ((i_arvalid && i_arready) || (i_wvalid && i_wready)))
    else $error("addr_ok without an ar or w handshake");

endmodule

bind axil_master_wrap tb_mem_subsys_sva u_sva (
  .i_aclk    (i_aclk),
  .i_rst_n   (i_rst_n),
  .i_awvalid (o_awvalid),
  .i_awready (i_awready),
  .i_wvalid  (o_wvalid),
  .i_wready  (i_wready),
  .i_arvalid (o_arvalid),
  .i_arready (i_arready),
  .i_addr_ok (o_rw_addr_ok)
);

// File: tb_mem_subsys.sv
// testbench for mem_subsys_top; applies the operation table and checks data against a memory model
`timescale 1ns/100ps

module tb_mem_subsys;

  localparam int MEM_AWORDS  = 6;
  localparam int WAIT_CYCLES = 2;
  localparam int DEPTH       = 1 << MEM_AWORDS;
  localparam int NUM_ROWS    = 14;
  localparam int CYCLE_LIMIT = (NUM_ROWS * (4 * WAIT_CYCLES + 10)) + 50;

  // completion codes, bit 0 = load/store, bit 1 = fetch
  localparam logic [1:0] PORT_NONE = 2'b00;
  localparam logic [1:0] PORT_LS   = 2'b01;
  localparam logic [1:0] PORT_IF   = 2'b10;

  typedef struct packed {
    logic [1:0]           port;
    logic                 wr;
    axil_pkg::axil_addr_t addr;
    axil_pkg::axil_strb_t strb;
    axil_pkg::axil_data_t wdata;
    logic                 rnd;    // replace wdata with a random word
    logic                 simul;  // fetch of the same address in the same cycle
  } op_t;

  logic                 aclk;
  logic                 rst_n;
  logic                 if_req;
  axil_pkg::axil_addr_t if_addr;
  logic                 if_data_ok;
  axil_pkg::axil_data_t if_rdata;
  logic                 ls_req;
  axil_pkg::rw_req_t    ls_req_data;
  logic                 ls_addr_ok;
  logic                 ls_data_ok;
  axil_pkg::axil_data_t ls_rdata;

  op_t                  ops [NUM_ROWS];
  axil_pkg::axil_data_t model [DEPTH];
  logic [31:0]          rng_state;
  int                   cycle_cnt;
  int                   err_cnt;

  mem_subsys_top #(
    .MEM_AWORDS  (MEM_AWORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_dut (
    .i_aclk        (aclk),
    .i_rst_n       (rst_n),
    .i_if_req      (if_req),
    .i_if_addr     (if_addr),
    .o_if_data_ok  (if_data_ok),
    .o_if_rdata    (if_rdata),
    .i_ls_req      (ls_req),
    .i_ls_req_data (ls_req_data),
    .o_ls_addr_ok  (ls_addr_ok),
    .o_ls_data_ok  (ls_data_ok),
    .o_ls_rdata    (ls_rdata)
  );

  always #10 aclk = ~aclk;  // 20 ns period

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  always @(posedge aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: the table did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic axil_pkg::axil_data_t next_rand64();
    logic [31:0] hi;
    rng_state = xorshift32(rng_state);
    hi        = rng_state;
    rng_state = xorshift32(rng_state);
    return {hi, rng_state};
  endfunction

  // word index wraps at the depth, upper address bits alias
  function automatic int model_index(input axil_pkg::axil_addr_t addr);
    return int'((addr / axil_pkg::STRB_WIDTH) % DEPTH);
  endfunction

  function automatic void model_write(input axil_pkg::axil_addr_t addr,
                                      input axil_pkg::axil_strb_t strb,
                                      input axil_pkg::axil_data_t data);
    int idx;
    idx = model_index(addr);
    for (int b = 0; b < axil_pkg::STRB_WIDTH; b++) begin
      if (strb[b]) model[idx][8*b +: 8] = data[8*b +: 8];  // byte merge
    end
  endfunction

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  task automatic report_error(input string msg);
    err_cnt++;
    $display("FAIL @%0t: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_data(input axil_pkg::axil_data_t got, input axil_pkg::axil_data_t exp,
                            input string what);
    if (got !== exp) begin
      report_error($sformatf("%s: read 0x%016h, expected 0x%016h", what, got, exp));
    end
  endtask

  task automatic check_port(input logic ls_ok, input logic if_ok, input logic [1:0] exp_port,
                            input string what);
    logic [1:0] got;
    got = {if_ok, ls_ok};
    if (got !== exp_port) begin
      report_error($sformatf("%s: data_ok pattern %b, expected %b", what, got, exp_port));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      report_error($sformatf("%s: counted %0d, expected %0d", what, got, exp));
    end
  endtask

  // --------------------------------------------------
  // operation table
  // --------------------------------------------------
  task automatic load_table();
    // port, wr, addr, strb, wdata, rnd, simul
    ops[0]  = '{PORT_LS, 1'b1, 32'h0000_0040, 8'hFF, 64'h1122_3344_5566_7788, 1'b0, 1'b0};
    ops[1]  = '{PORT_LS, 1'b0, 32'h0000_0040, 8'h00, 64'h0, 1'b0, 1'b0};
    ops[2]  = '{PORT_LS, 1'b1, 32'h0000_0048, 8'hFF, 64'h0, 1'b1, 1'b0};
    ops[3]  = '{PORT_LS, 1'b0, 32'h0000_0048, 8'h00, 64'h0, 1'b0, 1'b0};
    ops[4]  = '{PORT_LS, 1'b1, 32'h0000_0040, 8'h0F, 64'hAAAA_BBBB_CCCC_DDDD, 1'b0, 1'b0};
    ops[5]  = '{PORT_LS, 1'b0, 32'h0000_0040, 8'h00, 64'h0, 1'b0, 1'b0};
    ops[6]  = '{PORT_LS, 1'b1, 32'h0000_0048, 8'h3C, 64'h0, 1'b1, 1'b0};
    ops[7]  = '{PORT_LS, 1'b0, 32'h0000_0048, 8'h00, 64'h0, 1'b0, 1'b0};
    ops[8]  = '{PORT_IF, 1'b0, 32'h0000_0040, 8'h00, 64'h0, 1'b0, 1'b0};
    ops[9]  = '{PORT_LS, 1'b1, 32'h0000_0058, 8'hFF, 64'h0, 1'b1, 1'b1};
    ops[10] = '{PORT_LS, 1'b1, 32'h0000_0208, 8'hFF, 64'h0, 1'b1, 1'b0};  // beyond depth
    ops[11] = '{PORT_LS, 1'b0, 32'h0000_0008, 8'h00, 64'h0, 1'b0, 1'b0};
    ops[12] = '{PORT_IF, 1'b0, 32'h0000_0208, 8'h00, 64'h0, 1'b0, 1'b0};
    ops[13] = '{PORT_LS, 1'b0, 32'h0000_0058, 8'h00, 64'h0, 1'b0, 1'b1};
  endtask

  task automatic run_row(input op_t op, input int row);
    axil_pkg::rw_req_t    req;
    axil_pkg::axil_data_t wdata;
    axil_pkg::axil_data_t exp_ls;
    axil_pkg::axil_data_t exp_if;
    logic                 pend_ls;
    logic                 pend_if;
    int                   addr_cnt;
    pend_ls  = (op.port == PORT_LS) || op.simul;
    pend_if  = (op.port == PORT_IF) || op.simul;
    wdata    = op.rnd ? next_rand64() : op.wdata;
    addr_cnt = 0;
    exp_ls   = model[model_index(op.addr)];
    if (pend_ls && op.wr) model_write(op.addr, op.strb, wdata);
    exp_if   = model[model_index(op.addr)];  // fetch is served after load/store
    req = '{wr: op.wr, size: 2'd3, addr: op.addr, strb: op.strb, wdata: wdata};  // 8-byte beat

    @(posedge aclk);
    if (pend_ls) begin
      ls_req      <= 1'b1;
      ls_req_data <= req;
    end
    if (pend_if) begin
      if_req  <= 1'b1;
      if_addr <= op.addr;
    end

    while (pend_ls || pend_if) begin
      @(negedge aclk);
      if (ls_addr_ok) addr_cnt++;
      if (ls_data_ok || if_data_ok) begin
        check_port(ls_data_ok, if_data_ok, pend_ls ? PORT_LS : PORT_IF,
                   $sformatf("row %0d completion", row));
        if (pend_ls) begin
          if (!op.wr) check_data(ls_rdata, exp_ls, $sformatf("row %0d load", row));
          check_count(addr_cnt, 1, $sformatf("row %0d addr_ok pulses", row));
          pend_ls  = 1'b0;
          addr_cnt = 0;  // fetch owns the master from here
          @(posedge aclk);
          ls_req <= 1'b0;  // release after data_ok
        end else begin
          check_data(if_rdata, exp_if, $sformatf("row %0d fetch", row));
          check_count(addr_cnt, 0, $sformatf("row %0d addr_ok on load/store port", row));
          pend_if = 1'b0;
          @(posedge aclk);
          if_req <= 1'b0;
        end
      end
    end

    // data_ok and addr_ok are single-cycle pulses
    @(negedge aclk);
    check_port(ls_data_ok, if_data_ok, PORT_NONE, $sformatf("row %0d after release", row));
    check_count(int'(ls_addr_ok), 0, $sformatf("row %0d addr_ok after release", row));
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    aclk        = 1'b0;
    rst_n       = 1'b0;
    if_req      = 1'b0;
    if_addr     = '0;
    ls_req      = 1'b0;
    ls_req_data = '0;
    rng_state   = 32'h8782;
    cycle_cnt   = 0;
    err_cnt     = 0;
    load_table();

    repeat (8) @(posedge aclk);
    rst_n <= 1'b1;

    repeat (10) begin  // quiet ports after reset
      @(negedge aclk);
      check_port(ls_data_ok, if_data_ok, PORT_NONE, "idle after reset");
      check_count(int'(ls_addr_ok), 0, "addr_ok idle after reset");
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(ops[r], r);
    end

    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
axil_pkg.sv
mem_port_arbiter.sv
axil_master_wrap.sv
axil_sram_slave.sv
mem_subsys_top.sv
tb_mem_subsys_sva.sv
tb_mem_subsys.sv

// File: run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_mem_subsys --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation failed"
  exit 1
fi
